// ==== settings_ctrl.f ====
+incdir+verilog
verilog/vita_frame_pkg.sv
verilog/settings_cmd_pkg.sv
verilog/sync_fifo.sv
verilog/vita_cmd_parser.sv
verilog/cmd_executor.sv
verilog/ack_framer.sv
verilog/settings_fifo_ctrl.sv
verif/settings_fifo_ctrl_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the settings controller testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f settings_ctrl.f --top-module settings_fifo_ctrl_tb \
    -Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
    exit 0
fi
exit 1

// ==== verif/settings_fifo_ctrl_tb.sv ====
// --------------------
// settings fifo controller testbench
// directed command packets, ack and strobe checks
// --------------------
`timescale 1ns/1ps
`include "settings_ctrl_macros.svh"

module settings_fifo_ctrl_tb;
    import vita_frame_pkg::*;

    // tests take around 1500 cycles, limit leaves a wide margin
    localparam int MAX_CYCLES = 20000;

    logic clock;
    logic reset;
    logic clear;
    logic [35:0] in_data;
    logic in_valid;
    logic in_ready;
    logic [35:0] out_data;
    logic out_valid;
    logic out_ready;
    logic strobe;
    logic [7:0] addr;
    logic [31:0] data;
    logic [63:0] vita_time = '0;
    logic periph_ready;
    logic [`SFC_RB_WORDS*32-1:0] rb_words;

    // readback model, one word per rb_sel
    logic [31:0] rb_val [`SFC_RB_WORDS];
    // strobes seen on the bus, with the time the action saw
    logic [7:0] stb_addr [$];
    logic [31:0] stb_data [$];
    logic [63:0] stb_time [$];
    // back-pressure batch
    logic [31:0] bp_hdr [6];
    logic [31:0] bp_dat [6];
    bit sender_done;
    int errors = 0;
    int checks = 0;
    int cycles = 0;

    settings_fifo_ctrl dut0 (
        .clock(clock), .reset(reset), .clear(clear),
        .in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
        .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready),
        .strobe(strobe), .addr(addr), .data(data),
        .vita_time(vita_time), .periph_ready(periph_ready), .rb_words(rb_words)
    );

    initial clock = 1'b0;
    always #5 clock = ~clock;

    // --------------------
    // time base and strobe monitor
    // --------------------
    // recorded time is the value the action cycle compared against
    always @(negedge clock) begin
        if (strobe) begin
            stb_addr.push_back(addr);
            stb_data.push_back(data);
            stb_time.push_back(vita_time);
        end
        vita_time = vita_time + 64'd1;
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("errors=%0d checks=%0d", errors, checks);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic check_equal(input string test, input string what,
                               input logic [63:0] expected, input logic [63:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("ERROR %s %s: expected %h actual %h", test, what, expected, actual);
        end
    endtask

    task automatic check_true(input string test, input bit ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("%s: %s", test, msg);
        end
    endtask

    // seq 19:16, poke flag 8, set_addr 7:0
    function automatic logic [31:0] make_hdr(input logic [3:0] seq, input logic poke,
                                            input logic [7:0] set_addr);
        return {12'h000, seq, 7'h00, poke, set_addr};
    endfunction

    function automatic logic [35:0] frame_word(input logic [31:0] payload, input logic sof,
                                               input logic eof);
        logic [35:0] w;
        w = {4'h0, payload};
        w[SOF_BIT] = sof;
        w[EOF_BIT] = eof;
        return w;
    endfunction

    // --------------------
    // packet driver
    // --------------------
    task automatic send_packet(input bit sid, input bit cid, input bit tsi, input bit tsf,
                               input logic [63:0] ticks, input logic [31:0] hdr,
                               input logic [31:0] dat, input int extra);
        logic [35:0] words [$];
        logic [35:0] w;
        logic [31:0] vhdr;
        int i;
        bit rdy;
        vhdr = 32'h0000_0000;
        vhdr[HAS_SID_BIT] = sid;
        vhdr[HAS_CID_BIT] = cid;
        vhdr[TSI_HI:TSI_LO] = tsi ? 2'b01 : 2'b00;
        vhdr[TSF_HI:TSF_LO] = tsf ? 2'b01 : 2'b00;
        words.push_back(frame_word(32'h0000_0010, 1'b1, 1'b0));
        words.push_back(frame_word(vhdr, 1'b0, 1'b0));
        if (sid) words.push_back(frame_word($urandom(), 1'b0, 1'b0));
        if (cid) begin
            words.push_back(frame_word($urandom(), 1'b0, 1'b0));
            words.push_back(frame_word($urandom(), 1'b0, 1'b0));
        end
        if (tsi) words.push_back(frame_word($urandom(), 1'b0, 1'b0));
        if (tsf) begin
            words.push_back(frame_word(ticks[63:32], 1'b0, 1'b0));
            words.push_back(frame_word(ticks[31:0], 1'b0, 1'b0));
        end
        words.push_back(frame_word(hdr, 1'b0, 1'b0));
        words.push_back(frame_word(dat, 1'b0, 1'b0));
        for (i = 0; i < extra; i++) begin
            words.push_back(frame_word($urandom(), 1'b0, 1'b0));
        end
        w = words[words.size()-1];
        w[EOF_BIT] = 1'b1;
        words[words.size()-1] = w;
        i = 0;
        while (i < words.size()) begin
            in_data = words[i];
            in_valid = 1'b1;
            // in_ready only moves on a rising edge
            rdy = in_ready;
            @(negedge clock);
            if (rdy) i++;
        end
        in_valid = 1'b0;
    endtask

    // --------------------
    // ack collector, five words per command
    // --------------------
    task automatic get_ack(input string test, input logic [31:0] hdr);
        logic [35:0] expected [5];
        logic [31:0] prot;
        int n;
        // protocol header: byte count, frame bit 16, destination 18:17
        prot = {16'h0000, ACK_PROT_BYTES};
        prot[16] = 1'b1;
        prot[18:17] = `SFC_PROT_DEST;
        expected[0] = frame_word(prot, 1'b1, 1'b0);
        expected[1] = frame_word({ACK_VRT_TYPE, hdr[19:16], ACK_VRT_WORDS}, 1'b0, 1'b0);
        expected[2] = frame_word(`SFC_ACK_SID, 1'b0, 1'b0);
        expected[3] = frame_word(hdr, 1'b0, 1'b0);
        expected[4] = frame_word(rb_val[hdr[3:0]], 1'b0, 1'b1);
        n = 0;
        out_ready = 1'b1;
        while (n < 5) begin
            if (out_valid) begin
                check_equal(test, $sformatf("ack word %0d", n), 64'(expected[n]),
                            64'(out_data));
                n++;
            end
            @(negedge clock);
        end
        out_ready = 1'b0;
    endtask

    task automatic check_strobe(input string test, input logic [31:0] hdr,
                                input logic [31:0] dat, output logic [63:0] when);
        when = '0;
        check_true(test, stb_addr.size() > 0, "a strobe was expected but none was seen");
        if (stb_addr.size() > 0) begin
            check_equal(test, "strobe addr", 64'(hdr[7:0]), 64'(stb_addr.pop_front()));
            check_equal(test, "strobe data", 64'(dat), 64'(stb_data.pop_front()));
            when = stb_time.pop_front();
        end
    endtask

    // --------------------
    // directed tests
    // --------------------
    task automatic test_plain_poke();
        logic [31:0] hdr;
        logic [31:0] dat;
        logic [63:0] when;
        hdr = make_hdr(4'd1, 1'b1, 8'h35);
        dat = $urandom();
        send_packet(1'b0, 1'b0, 1'b0, 1'b0, 64'd0, hdr, dat, 0);
        get_ack("plain_poke", hdr);
        check_strobe("plain_poke", hdr, dat, when);
        check_equal("plain_poke", "extra strobes", 64'd0, 64'(stb_addr.size()));
    endtask

    task automatic test_peek();
        logic [31:0] hdr;
        int k;
        for (k = 0; k < 3; k++) begin
            hdr = make_hdr(4'(3 + k), 1'b0, {4'h0, 4'($urandom())});
            send_packet(1'b0, 1'b0, 1'b0, 1'b0, 64'd0, hdr, $urandom(), 0);
            get_ack("peek", hdr);
            check_equal("peek", "strobes", 64'd0, 64'(stb_addr.size()));
        end
    endtask

    task automatic test_optional_fields();
        logic [31:0] hdr;
        logic [31:0] dat;
        logic [63:0] when;
        // sid, cid and tsi ahead of the command, three words after the data
        hdr = make_hdr(4'd7, 1'b1, 8'hc7);
        dat = $urandom();
        send_packet(1'b1, 1'b1, 1'b1, 1'b0, 64'd0, hdr, dat, 3);
        get_ack("optional_fields", hdr);
        check_strobe("optional_fields", hdr, dat, when);
        // sid alone, one extra word
        hdr = make_hdr(4'd8, 1'b1, 8'h1e);
        dat = $urandom();
        send_packet(1'b1, 1'b0, 1'b0, 1'b0, 64'd0, hdr, dat, 1);
        get_ack("optional_sid", hdr);
        check_strobe("optional_sid", hdr, dat, when);
    endtask

    task automatic test_timed();
        logic [31:0] hdr;
        logic [31:0] dat;
        logic [63:0] ticks;
        logic [63:0] start;
        logic [63:0] when;
        hdr = make_hdr(4'd10, 1'b1, 8'h5a);
        dat = $urandom();
        ticks = vita_time + 64'd300;
        send_packet(1'b0, 1'b0, 1'b0, 1'b1, ticks, hdr, dat, 0);
        while (vita_time < ticks - 64'd5) @(negedge clock);
        check_equal("timed", "strobes before time", 64'd0, 64'(stb_addr.size()));
        get_ack("timed", hdr);
        check_strobe("timed", hdr, dat, when);
        check_true("timed", when >= ticks, "strobe fired before vita_time reached the ticks");
        // time already passed, no hold expected
        hdr = make_hdr(4'd11, 1'b1, 8'ha3);
        dat = $urandom();
        ticks = vita_time - 64'd100;
        start = vita_time;
        send_packet(1'b0, 1'b0, 1'b0, 1'b1, ticks, hdr, dat, 0);
        get_ack("timed_late", hdr);
        check_strobe("timed_late", hdr, dat, when);
        check_true("timed_late", when <= start + 64'd20, "late timed command was held back");
    endtask

    task automatic send_batch();
        int j;
        for (j = 0; j < 6; j++) begin
            send_packet(1'b0, 1'b0, 1'b0, 1'b0, 64'd0, bp_hdr[j], bp_dat[j], 0);
        end
        sender_done = 1'b1;
    endtask

    task automatic test_backpressure();
        logic [63:0] when;
        int k;
        int low_run;
        int waited;
        periph_ready = 1'b0;
        for (k = 0; k < 6; k++) begin
            bp_hdr[k] = make_hdr(4'(12 + k), 1'b1, 8'(8'h60 + k));
            bp_dat[k] = $urandom();
        end
        sender_done = 1'b0;
        fork
            send_batch();
        join_none
        // four queued, one held in the parser, input closes
        low_run = 0;
        waited = 0;
        while (low_run < 20 && waited < 400) begin
            if (in_ready) low_run = 0;
            else low_run++;
            waited++;
            @(negedge clock);
        end
        check_true("backpressure", low_run >= 20, "in_ready never stayed low with queues full");
        check_true("backpressure", !sender_done, "all six commands got in past full queues");
        check_equal("backpressure", "strobes while stalled", 64'd0, 64'(stb_addr.size()));
        periph_ready = 1'b1;
        // four results fill the ack queue, then the executor waits
        repeat (30) @(negedge clock);
        check_equal("backpressure", "strobes with ack queue full", 64'd4,
                    64'(stb_addr.size()));
        for (k = 0; k < 6; k++) begin
            get_ack("backpressure", bp_hdr[k]);
        end
        check_true("backpressure", sender_done, "the sender never finished the batch");
        for (k = 0; k < 6; k++) begin
            check_strobe("backpressure", bp_hdr[k], bp_dat[k], when);
        end
    endtask

    task automatic test_clear();
        logic [31:0] hdr;
        logic [31:0] dat;
        logic [63:0] when;
        bit seen_valid;
        periph_ready = 1'b0;
        hdr = make_hdr(4'd2, 1'b1, 8'h42);
        send_packet(1'b0, 1'b0, 1'b0, 1'b0, 64'd0, hdr, $urandom(), 0);
        repeat (10) @(negedge clock);
        clear = 1'b1;
        @(negedge clock);
        clear = 1'b0;
        periph_ready = 1'b1;
        seen_valid = 1'b0;
        repeat (50) begin
            if (out_valid) seen_valid = 1'b1;
            @(negedge clock);
        end
        check_equal("clear", "strobes after clear", 64'd0, 64'(stb_addr.size()));
        check_true("clear", !seen_valid, "an acknowledge appeared for a cleared command");
        // queue works normally afterwards
        hdr = make_hdr(4'd3, 1'b1, 8'h99);
        dat = $urandom();
        send_packet(1'b0, 1'b0, 1'b0, 1'b0, 64'd0, hdr, dat, 0);
        get_ack("clear_after", hdr);
        check_strobe("clear_after", hdr, dat, when);
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        void'($urandom(2925));
        reset = 1'b1;
        clear = 1'b0;
        in_data = '0;
        in_valid = 1'b0;
        out_ready = 1'b0;
        periph_ready = 1'b1;
        rb_words = '0;
        sender_done = 1'b0;
        for (int i = 0; i < `SFC_RB_WORDS; i++) begin
            rb_val[i] = $urandom();
            rb_words[i*32 +: 32] = rb_val[i];
        end
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        @(negedge clock);
        test_plain_poke();
        test_peek();
        test_optional_fields();
        test_timed();
        test_backpressure();
        test_clear();
        repeat (10) @(negedge clock);
        check_equal("final", "unexpected strobes", 64'd0, 64'(stb_addr.size()));
        $display("errors=%0d checks=%0d", errors, checks);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog/settings_fifo_ctrl.sv ====
// --------------------
// settings and readback controller
// command packets in, bus strobes and ack packets out
// --------------------
`timescale 1ns/1ps
`include "settings_ctrl_macros.svh"

module settings_fifo_ctrl (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                clear,
    input  logic [vita_frame_pkg::FRAME_W-1:0]  in_data,
    input  logic                                in_valid,
    output logic                                in_ready,
    output logic [vita_frame_pkg::FRAME_W-1:0]  out_data,
    output logic                                out_valid,
    input  logic                                out_ready,
    output logic                                strobe,
    output logic [7:0]                          addr,
    output logic [31:0]                         data,
    input  logic [63:0]                         vita_time,
    input  logic                                periph_ready,
    input  logic [`SFC_RB_WORDS*32-1:0]         rb_words
);

    // --------------------
    // command path
    // --------------------
    logic [`SFC_CMD_W-1:0] cmd_wdata;
    logic [`SFC_CMD_W-1:0] cmd_rdata;
    logic cmd_write, cmd_full, cmd_read, cmd_empty;

    // --------------------
    // result path
    // --------------------
    logic [`SFC_RES_W-1:0] res_wdata;
    logic [`SFC_RES_W-1:0] res_rdata;
    logic res_write, res_full, res_read, res_empty;

    vita_cmd_parser parser0 (
        .clock(clock), .reset(reset),
        .in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
        .cmd_wdata(cmd_wdata), .cmd_write(cmd_write), .cmd_full(cmd_full)
    );

    sync_fifo #(.WIDTH(`SFC_CMD_W), .AW(`SFC_FIFO_AW)) cmd_fifo (
        .clock(clock), .reset(reset), .clear(clear),
        .wdata(cmd_wdata), .write(cmd_write), .full(cmd_full),
        .rdata(cmd_rdata), .read(cmd_read), .empty(cmd_empty)
    );

    cmd_executor exec0 (
        .clock(clock), .reset(reset), .clear(clear),
        .cmd_rdata(cmd_rdata), .cmd_empty(cmd_empty), .cmd_read(cmd_read),
        .vita_time(vita_time), .periph_ready(periph_ready), .rb_words(rb_words),
        .res_wdata(res_wdata), .res_write(res_write), .res_full(res_full),
        .strobe(strobe), .addr(addr), .data(data)
    );

    sync_fifo #(.WIDTH(`SFC_RES_W), .AW(`SFC_FIFO_AW)) res_fifo (
        .clock(clock), .reset(reset), .clear(clear),
        .wdata(res_wdata), .write(res_write), .full(res_full),
        .rdata(res_rdata), .read(res_read), .empty(res_empty)
    );

    ack_framer framer0 (
        .clock(clock), .reset(reset),
        .res_rdata(res_rdata), .res_empty(res_empty), .res_read(res_read),
        .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready)
    );

endmodule

// ==== verilog/ack_framer.sv ====
// --------------------
// acknowledge framer
// five frame words per result entry
// --------------------
`timescale 1ns/1ps
`include "settings_ctrl_macros.svh"

module ack_framer (
    input  logic                                clock,
    input  logic                                reset,
    input  logic [`SFC_RES_W-1:0]               res_rdata,
    input  logic                                res_empty,
    output logic                                res_read,
    output logic [vita_frame_pkg::FRAME_W-1:0]  out_data,
    output logic                                out_valid,
    input  logic                                out_ready
);
    import vita_frame_pkg::*;
    import settings_cmd_pkg::*;

    localparam logic [2:0] W_PROT = 3'd0;
    localparam logic [2:0] W_VRT = 3'd1;
    localparam logic [2:0] W_SID = 3'd2;
    localparam logic [2:0] W_HDR = 3'd3;
    localparam logic [2:0] W_DATA = 3'd4;

    logic [2:0] word_cnt;
    cmd_hdr_t res_hdr;
    logic [31:0] res_data;
    logic [31:0] word;
    logic writing;
    logic last;

    assign {res_hdr, res_data} = res_rdata;
    assign out_valid = !res_empty;
    assign writing = out_valid && out_ready;
    assign last = (word_cnt == W_DATA);
    // eof transfer retires the result
    assign res_read = writing && last;

    always_ff @(posedge clock) begin
        if (reset) word_cnt <= W_PROT;
        else if (writing) word_cnt <= last ? W_PROT : word_cnt + 3'd1;
    end

    // payload per word position
    always_comb begin
        case (word_cnt)
            // length, frame bit, destination
            W_PROT: word = {13'd0, `SFC_PROT_DEST, 1'b1, ACK_PROT_BYTES};
            W_VRT: word = {ACK_VRT_TYPE, res_hdr.peek.seq, ACK_VRT_WORDS};
            W_SID: word = `SFC_ACK_SID;
            W_HDR: word = res_hdr;
            default: word = res_data;
        endcase
    end

    always_comb begin
        out_data = '0;
        out_data[31:0] = word;
        out_data[SOF_BIT] = (word_cnt == W_PROT);
        out_data[EOF_BIT] = last;
    end

endmodule

// ==== verilog/cmd_executor.sv ====
// --------------------
// command executor
// waits for time and readiness, pokes the bus, queues the result
// --------------------
`timescale 1ns/1ps
`include "settings_ctrl_macros.svh"

module cmd_executor (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         clear,
    input  logic [`SFC_CMD_W-1:0]        cmd_rdata,
    input  logic                         cmd_empty,
    output logic                         cmd_read,
    input  logic [63:0]                  vita_time,
    input  logic                         periph_ready,
    input  logic [`SFC_RB_WORDS*32-1:0]  rb_words,
    output logic [`SFC_RES_W-1:0]        res_wdata,
    output logic                         res_write,
    input  logic                         res_full,
    output logic                         strobe,
    output logic [7:0]                   addr,
    output logic [31:0]                  data
);
    import settings_cmd_pkg::*;

    localparam logic S_LOAD = 1'b0;
    localparam logic S_EVENT = 1'b1;

    logic state;
    // fifo head fields
    logic [63:0] head_ticks;
    cmd_hdr_t head_hdr;
    logic [31:0] head_data;
    logic head_has_time;
    // loaded command
    logic [63:0] ticks_reg;
    cmd_hdr_t hdr_reg;
    logic [31:0] data_reg;
    logic has_time_reg;
    logic [31:0] rb_data;
    logic time_ready;
    logic action;
    logic strobe_reg;

    assign {head_ticks, head_hdr, head_data, head_has_time} = cmd_rdata;

    // untimed and late commands go at once
    assign time_ready = !has_time_reg || (vita_time >= ticks_reg);
    assign action = (state == S_EVENT) && !res_full && periph_ready && time_ready;

    // pop and push on the same cycle
    assign cmd_read = action;
    assign res_write = action;
    assign res_wdata = {hdr_reg, rb_data};

    // --------------------
    // load / event
    // --------------------
    always_ff @(posedge clock) begin
        if (reset || clear) begin
            state <= S_LOAD;
        end else if (state == S_LOAD) begin
            if (!cmd_empty) state <= S_EVENT;
        end else if (action) begin
            state <= S_LOAD;
        end
    end

    // head capture and readback select while loading
    always_ff @(posedge clock) begin
        if (state == S_LOAD) begin
            ticks_reg <= head_ticks;
            hdr_reg <= head_hdr;
            data_reg <= head_data;
            has_time_reg <= head_has_time;
            rb_data <= rb_words[head_hdr.peek.rb_sel*32 +: 32];
        end
    end

    // strobe rises the cycle after a poke action
    always_ff @(posedge clock) begin
        if (reset || clear) strobe_reg <= 1'b0;
        else strobe_reg <= action && hdr_reg.poke.poke;
    end

    assign strobe = strobe_reg;
    assign addr = hdr_reg.poke.set_addr;
    assign data = data_reg;

    // the loaded command stays at the fifo head until its action
    a_head_held: assert property (@(posedge clock) disable iff (reset)
        (state == S_EVENT) |-> !cmd_empty);

endmodule

// ==== verilog/vita_cmd_parser.sv ====
// --------------------
// command packet parser
// walks the vita header and optional fields
// one command fifo entry per packet
// --------------------
`timescale 1ns/1ps
`include "settings_ctrl_macros.svh"

module vita_cmd_parser (
    input  logic                                clock,
    input  logic                                reset,
    input  logic [vita_frame_pkg::FRAME_W-1:0]  in_data,
    input  logic                                in_valid,
    output logic                                in_ready,
    output logic [`SFC_CMD_W-1:0]               cmd_wdata,
    output logic                                cmd_write,
    input  logic                                cmd_full
);
    import vita_frame_pkg::*;

    localparam logic [3:0] S_LINE0    = 4'd0;
    localparam logic [3:0] S_VITA_HDR = 4'd1;
    localparam logic [3:0] S_SID      = 4'd2;
    localparam logic [3:0] S_CID0     = 4'd3;
    localparam logic [3:0] S_CID1     = 4'd4;
    localparam logic [3:0] S_TSI      = 4'd5;
    localparam logic [3:0] S_TSF0     = 4'd6;
    localparam logic [3:0] S_TSF1     = 4'd7;
    localparam logic [3:0] S_CMD_HDR  = 4'd8;
    localparam logic [3:0] S_DATA     = 4'd9;
    localparam logic [3:0] S_WAIT_EOF = 4'd10;
    localparam logic [3:0] S_STORE    = 4'd11;

    logic [3:0] state;
    logic reading;
    logic in_sid, in_cid, in_tsi, in_tsf, in_eof;
    // flags from the vita header word
    logic has_cid_reg, has_tsi_reg, has_tsf_reg;
    logic [63:0] ticks_reg;
    logic [31:0] hdr_reg;
    logic [31:0] data_reg;

    // first optional field still to come or the command header
    function automatic logic [3:0] next_field(input logic sid, input logic cid,
                                              input logic tsi, input logic tsf);
        if (sid) return S_SID;
        if (cid) return S_CID0;
        if (tsi) return S_TSI;
        if (tsf) return S_TSF0;
        return S_CMD_HDR;
    endfunction

    assign reading = in_valid && in_ready;
    assign in_sid = in_data[HAS_SID_BIT];
    assign in_cid = in_data[HAS_CID_BIT];
    assign in_tsi = |in_data[TSI_HI:TSI_LO];
    assign in_tsf = |in_data[TSF_HI:TSF_LO];
    assign in_eof = in_data[EOF_BIT];

    // only the store state blocks input
    assign in_ready = (state != S_STORE);
    assign cmd_write = (state == S_STORE) && !cmd_full;
    assign cmd_wdata = {ticks_reg, hdr_reg, data_reg, has_tsf_reg};

    // --------------------
    // packet walk
    // --------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= S_LINE0;
        end else begin
            case (state)
                S_LINE0: if (reading) state <= S_VITA_HDR;
                // live flags pick the first field
                S_VITA_HDR: if (reading) state <= next_field(in_sid, in_cid, in_tsi, in_tsf);
                S_SID: if (reading) state <= next_field(1'b0, has_cid_reg, has_tsi_reg, has_tsf_reg);
                S_CID0: if (reading) state <= S_CID1;
                S_CID1: if (reading) state <= next_field(1'b0, 1'b0, has_tsi_reg, has_tsf_reg);
                S_TSI: if (reading) state <= next_field(1'b0, 1'b0, 1'b0, has_tsf_reg);
                S_TSF0: if (reading) state <= S_TSF1;
                S_TSF1: if (reading) state <= S_CMD_HDR;
                S_CMD_HDR: if (reading) state <= S_DATA;
                // extra payload words get swallowed until eof
                S_DATA: if (reading) state <= in_eof ? S_STORE : S_WAIT_EOF;
                S_WAIT_EOF: if (reading && in_eof) state <= S_STORE;
                S_STORE: if (!cmd_full) state <= S_LINE0;
                default: state <= S_LINE0;
            endcase
        end
    end

    // field capture from the payload bits
    always_ff @(posedge clock) begin
        if (reading) begin
            case (state)
                S_VITA_HDR: begin
                    has_cid_reg <= in_cid;
                    has_tsi_reg <= in_tsi;
                    has_tsf_reg <= in_tsf;
                end
                S_TSF0: ticks_reg[63:32] <= in_data[31:0];
                S_TSF1: ticks_reg[31:0] <= in_data[31:0];
                S_CMD_HDR: hdr_reg <= in_data[31:0];
                S_DATA: data_reg <= in_data[31:0];
                default: ;
            endcase
        end
    end

    // a new packet begins only in line 0 and the walk ends with its eof
    a_sof_align: assert property (@(posedge clock) disable iff (reset)
        reading |-> (in_data[SOF_BIT] == (state == S_LINE0)));

endmodule

// ==== verilog/sync_fifo.sv ====
// --------------------
// synchronous fifo with count based flags
// --------------------
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int AW = 2
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             clear,
    input  logic [WIDTH-1:0] wdata,
    input  logic             write,
    output logic             full,
    output logic [WIDTH-1:0] rdata,
    input  logic             read,
    output logic             empty
);

    logic [WIDTH-1:0] mem [2**AW];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    // one extra bit, msb set only at 2**AW entries
    logic [AW:0] count;

    assign full = count[AW];
    assign empty = (count == '0);
    // head is always visible
    assign rdata = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (write && !full) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (write && !full) wr_ptr <= wr_ptr + 1'b1;
            if (read && !empty) rd_ptr <= rd_ptr + 1'b1;
            // simultaneous push and pop leaves the count alone
            count <= count + (AW+1)'(write && !full) - (AW+1)'(read && !empty);
        end
    end

    a_no_overflow: assert property (@(posedge clock) disable iff (reset) write |-> !full);
    a_no_underflow: assert property (@(posedge clock) disable iff (reset) read |-> !empty);

endmodule

// ==== verilog/settings_cmd_pkg.sv ====
// --------------------
// command header word, poke and peek decodings
// --------------------
package settings_cmd_pkg;

    // poke view, write set_addr on the settings bus
    typedef struct packed {
        logic [11:0] rsvd_hi;
        logic [3:0]  seq;
        logic [6:0]  rsvd_lo;
        logic        poke;
        logic [7:0]  set_addr;
    } cmd_poke_t;

    // peek view, low nibble picks a readback word
    typedef struct packed {
        logic [11:0] rsvd_hi;
        logic [3:0]  seq;
        logic [11:0] rsvd_lo;
        logic [3:0]  rb_sel;
    } cmd_peek_t;

    // one header word, both views overlap
    typedef union packed {
        cmd_poke_t poke;
        cmd_peek_t peek;
    } cmd_hdr_t;

endpackage

// ==== verilog/vita_frame_pkg.sv ====
// --------------------
// frame word and vita header bit positions
// --------------------
package vita_frame_pkg;

    // 36-bit frame word, sof and eof above the payload
    localparam int FRAME_W = 36;
    localparam int SOF_BIT = 32;
    localparam int EOF_BIT = 33;

    // optional field flags in the vita header word
    localparam int HAS_SID_BIT = 28;
    localparam int HAS_CID_BIT = 27;
    localparam int TSI_HI = 23;
    localparam int TSI_LO = 22;
    localparam int TSF_HI = 21;
    localparam int TSF_LO = 20;

    // --------------------
    // acknowledge packet constants
    // --------------------
    // packet type prefix of the ack vita header
    localparam logic [11:0] ACK_VRT_TYPE = 12'b0101_0000_0000;
    // ack vita packet length in words
    localparam logic [15:0] ACK_VRT_WORDS = 16'd4;
    // bytes following the protocol header
    localparam logic [15:0] ACK_PROT_BYTES = 16'd16;

endpackage

// ==== verilog/settings_ctrl_macros.svh ====
// --------------------
// settings controller build constants
// fifo sizing, ack addressing and entry widths
// --------------------
`ifndef SETTINGS_CTRL_MACROS_SVH
`define SETTINGS_CTRL_MACROS_SVH

// fifo address width, 2 gives four entries
`define SFC_FIFO_AW 2
// protocol framer destination in the ack header
`define SFC_PROT_DEST 2'd0
// stream id carried in the third ack word
`define SFC_ACK_SID 32'h0000_0ac4
// sixteen readback words of 32 bits
`define SFC_RB_WORDS 16
// command entry: ticks, header, data, has-time
`define SFC_CMD_W 129
// result entry: header, readback data
`define SFC_RES_W 64

`endif
